// File: hw/subsys_macros.svh
// Subsystem constants: bus widths, servo channel count,
// ID register value and PWM step divider

`ifndef SUBSYS_MACROS_SVH
`define SUBSYS_MACROS_SVH

// Register bus
`define SUBSYS_ADDR_W   6       // Register address bits
`define SUBSYS_DATA_W   8       // Register data bits

// Servo PWM
`define SUBSYS_SERVO_N  4       // Arm servo channels
`define SUBSYS_PWM_DIV  4       // Clocks per PWM step, 256 steps per period

// Identification
`define SUBSYS_ID       8'hB5   // Fixed value of the ID register

`endif

// File: hw/subsys_pkg.sv
// Register bus types and the register map of the control subsystem

`include "subsys_macros.svh"

package subsys_pkg;

    typedef logic [`SUBSYS_ADDR_W-1:0] reg_addr_t;     // Register address
    typedef logic [`SUBSYS_DATA_W-1:0] reg_data_t;     // Register data byte

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////
    typedef enum reg_addr_t {
        REG_ID         = 'h00,  // Read only, fixed ID
        REG_SERVO_EN   = 'h01,  // Bits 3:0 servo channel enables
        REG_LED        = 'h02,  // Test mode and LED test values
        REG_SCRATCH    = 'h03,  // Free scratch byte
        REG_SERVO_POS0 = 'h04,  // Servo 0 position
        REG_SERVO_POS1 = 'h05,  // Servo 1 position
        REG_SERVO_POS2 = 'h06,  // Servo 2 position
        REG_SERVO_POS3 = 'h07,  // Servo 3 position
        REG_FAULT      = 'h08   // Read only, sampled faults
    } reg_index_e;

endpackage

// File: hw/reg_bus_if.sv
// Register bus between the SPI target and the register file

`timescale 1ns/1ps

interface reg_bus_if
    import subsys_pkg::*;
();

    reg_addr_t address;     // Register address, valid with either strobe
    logic      write_en;    // One cycle write strobe
    reg_data_t wr_data;     // Write data
    logic      read_en;     // One cycle read strobe
    reg_data_t rd_data;     // Read data, valid the cycle after read_en

    // SPI side issues the strobes
    modport host   (output address, write_en, wr_data, read_en, input rd_data);

    // Register file answers reads
    modport target (input address, write_en, wr_data, read_en, output rd_data);

endinterface

// File: hw/spi_target.sv
// SPI mode 0 target, oversampled in the system clock domain,
// turning two-byte transactions into register bus strobes

`timescale 1ns/1ps

module spi_target
    import subsys_pkg::*;
(
    input  logic       clock,       // System clock
    input  logic       reset_n,     // Async reset, active low
    input  logic       spi_clock,   // SPI clock from the host
    input  logic       cs_n,        // Chip select, active low
    input  logic       mosi,        // Host to target data
    output logic       miso,        // Target to host data
    reg_bus_if.host    bus          // Register bus master side
);

    logic [2:0] sclk_sync;          // Two sync stages plus edge history
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise, sclk_fall;
    logic       cs_s, mosi_s;
    logic [4:0] bit_cnt;            // Rising edges seen, stops at 16
    logic [6:0] rx_shift;           // Bits received so far in this byte
    logic [7:0] rx_byte;            // Byte completed by the current bit
    logic       byte0_done, byte1_done;
    logic       cmd_write;          // Command bit 7
    reg_addr_t  cmd_addr;           // Command bits 5:0
    reg_data_t  wr_byte;
    logic [1:0] cmd_pipe, data_pipe;
    logic       read_q, write_q;
    logic       rd_load;            // rd_data is valid this cycle
    reg_data_t  tx_shift, tx_next;
    logic       miso_q;

    ////////////////////////////////////////////////////////////
    // Pin synchronizers and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sclk_sync <= '0;
            cs_sync   <= 2'b11;     // Deselected
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    assign sclk_rise  = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall  = ~sclk_sync[1] & sclk_sync[2];
    assign cs_s       = cs_sync[1];
    assign mosi_s     = mosi_sync[1];
    assign rx_byte    = {rx_shift, mosi_s};
    assign byte0_done = ~cs_s & sclk_rise & (bit_cnt == 5'd7);     // Bit 8 edge
    assign byte1_done = ~cs_s & sclk_rise & (bit_cnt == 5'd15);    // Bit 16 edge

    always_ff @(posedge clock) begin
        if (sclk_rise)
            rx_shift <= rx_byte[6:0];                   // MSB first
    end

    ////////////////////////////////////////////////////////////
    // Bit counter, command decode and bus strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt   <= '0;
            cmd_write <= 1'b0;
            cmd_addr  <= '0;
            wr_byte   <= '0;
            cmd_pipe  <= '0;
            data_pipe <= '0;
            read_q    <= 1'b0;
            write_q   <= 1'b0;
        end else begin
            cmd_pipe  <= {cmd_pipe[0], byte0_done};
            data_pipe <= {data_pipe[0], byte1_done};
            read_q    <= cmd_pipe[1] & ~cmd_write;      // 3 cycles after bit 8
            write_q   <= data_pipe[1] & cmd_write;      // 3 cycles after bit 16
            if (cs_s)
                bit_cnt <= '0;                          // Abort or idle
            else if (sclk_rise && bit_cnt != 5'd16)
                bit_cnt <= bit_cnt + 5'd1;
            if (byte0_done) begin
                cmd_write <= rx_byte[7];
                cmd_addr  <= rx_byte[5:0];              // Bit 6 ignored
            end
            if (byte1_done)
                wr_byte <= rx_byte;
        end
    end

    assign bus.address  = cmd_addr;
    assign bus.wr_data  = wr_byte;
    assign bus.read_en  = read_q;
    assign bus.write_en = write_q;

    ////////////////////////////////////////////////////////////
    // Read data shifter
    ////////////////////////////////////////////////////////////
    assign tx_next = rd_load ? bus.rd_data : tx_shift;  // Fresh byte wins

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_load  <= 1'b0;
            tx_shift <= '0;
            miso_q   <= 1'b0;
        end else if (cs_s) begin
            rd_load  <= 1'b0;
            tx_shift <= '0;
            miso_q   <= 1'b0;
        end else begin
            rd_load <= read_q;
            if (sclk_fall) begin
                miso_q   <= tx_next[7];                 // Next bit on falling edge
                tx_shift <= {tx_next[6:0], 1'b0};
            end else begin
                tx_shift <= tx_next;
            end
        end
    end

    assign miso = miso_q & ~cs_n;                       // Quiet while deselected

endmodule

// File: hw/reg_file.sv
// Register file: configuration storage, address decode, read data,
// fault input sampling and the status LED multiplexer

`timescale 1ns/1ps
`include "subsys_macros.svh"

module reg_file
    import subsys_pkg::*;
(
    input  logic                       clock,       // System clock
    input  logic                       reset_n,     // Async reset, active low
    reg_bus_if.target                  bus,         // Register bus slave side
    input  logic [3:0]                 sr_fault,    // Motor fault inputs
    output logic [`SUBSYS_SERVO_N-1:0] servo_en,    // Servo channel enables
    output reg_data_t                  servo_pos [`SUBSYS_SERVO_N],
    output logic                       status_fault,
    output logic                       status_pi,
    output logic                       status_ps4,
    output logic                       status_debug
);

    reg_data_t  en_reg;             // REG_SERVO_EN
    reg_data_t  led_reg;            // REG_LED
    reg_data_t  scratch_reg;        // REG_SCRATCH
    logic [3:0] fault_meta;
    logic [3:0] fault_s;            // Synchronized faults
    reg_data_t  rd_next;
    reg_data_t  rd_q;

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            en_reg      <= '0;
            led_reg     <= '0;
            scratch_reg <= '0;
            servo_pos   <= '{default: '0};
        end else if (bus.write_en) begin
            case (bus.address)
                REG_SERVO_EN:   en_reg       <= bus.wr_data;
                REG_LED:        led_reg      <= bus.wr_data;
                REG_SCRATCH:    scratch_reg  <= bus.wr_data;
                REG_SERVO_POS0: servo_pos[0] <= bus.wr_data;
                REG_SERVO_POS1: servo_pos[1] <= bus.wr_data;
                REG_SERVO_POS2: servo_pos[2] <= bus.wr_data;
                REG_SERVO_POS3: servo_pos[3] <= bus.wr_data;
                default: ;                      // ID, fault and unmapped
            endcase
        end
    end

    // Fault inputs come straight from the motor drivers
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fault_meta <= '0;
            fault_s    <= '0;
        end else begin
            fault_meta <= sr_fault;
            fault_s    <= fault_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (bus.address)
            REG_ID:         rd_next = `SUBSYS_ID;
            REG_SERVO_EN:   rd_next = en_reg;
            REG_LED:        rd_next = led_reg;
            REG_SCRATCH:    rd_next = scratch_reg;
            REG_SERVO_POS0: rd_next = servo_pos[0];
            REG_SERVO_POS1: rd_next = servo_pos[1];
            REG_SERVO_POS2: rd_next = servo_pos[2];
            REG_SERVO_POS3: rd_next = servo_pos[3];
            REG_FAULT:      rd_next = reg_data_t'(fault_s);
            default:        rd_next = '0;           // Unmapped reads 0
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            rd_q <= '0;
        else if (bus.read_en)
            rd_q <= rd_next;                        // Held until the next read
    end

    assign bus.rd_data = rd_q;
    assign servo_en    = en_reg[`SUBSYS_SERVO_N-1:0];

    // LED mux, bit 0 of REG_LED selects test mode
    assign status_fault = led_reg[0] ? led_reg[1] : |fault_s;
    assign status_pi    = led_reg[0] ? 1'b1       : led_reg[2];
    assign status_ps4   = led_reg[0] ? 1'b1       : led_reg[3];
    assign status_debug = led_reg[0] ? led_reg[4] : 1'b1;

endmodule

// File: hw/servo_pwm.sv
// Four-channel servo PWM, shared step prescaler and 256-step period,
// settings applied at each period start

`timescale 1ns/1ps
`include "subsys_macros.svh"

module servo_pwm
    import subsys_pkg::*;
(
    input  logic                       clock,       // System clock
    input  logic                       reset_n,     // Async reset, active low
    input  logic [`SUBSYS_SERVO_N-1:0] servo_en,    // Channel enables
    input  reg_data_t                  servo_pos [`SUBSYS_SERVO_N],
    output logic [`SUBSYS_SERVO_N-1:0] servo_out    // PWM outputs
);

    localparam int PRESC_W = $clog2(`SUBSYS_PWM_DIV);

    logic [PRESC_W-1:0]        presc;           // Clocks within a step
    logic                      step_tick;
    logic [7:0]                step_cnt;        // Step within the period
    logic                      wrap;            // Last clock of the period
    logic [`SUBSYS_SERVO_N-1:0] en_q;           // Enables for this period
    reg_data_t                 pos_q [`SUBSYS_SERVO_N];

    assign step_tick = (presc == PRESC_W'(`SUBSYS_PWM_DIV - 1));
    assign wrap      = step_tick && (step_cnt == 8'hFF);

    ////////////////////////////////////////////////////////////
    // Prescaler and period counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            presc    <= '0;
            step_cnt <= '0;
        end else begin
            presc <= step_tick ? '0 : presc + 1'b1;
            if (step_tick)
                step_cnt <= step_cnt + 8'd1;    // Wraps at 256
        end
    end

    ////////////////////////////////////////////////////////////
    // Per channel latch and compare
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            en_q      <= '0;
            pos_q     <= '{default: '0};
            servo_out <= '0;
        end else begin
            for (int i = 0; i < `SUBSYS_SERVO_N; i++) begin
                if (wrap) begin
                    en_q[i]  <= servo_en[i];    // New values at period start
                    pos_q[i] <= servo_pos[i];
                end
                servo_out[i] <= en_q[i] && (step_cnt < pos_q[i]);
            end
        end
    end

endmodule

// File: hw/subsys_top.sv
// Control subsystem top: SPI target, register file and servo PWM
// joined by the register bus

`timescale 1ns/1ps
`include "subsys_macros.svh"

module subsys_top
    import subsys_pkg::*;
(
    input  logic       clock,           // System clock
    input  logic       reset_n,         // Async reset, active low
    input  logic       spi_clock,       // SPI clock
    input  logic       cs_n,            // SPI chip select
    input  logic       mosi,            // SPI data in
    output logic       miso,            // SPI data out
    input  logic [3:0] sr_fault,        // Motor fault inputs
    output logic [3:0] servo_pwm,       // Arm servo PWM outputs
    output logic       status_fault,    // Fault LED
    output logic       status_pi,       // Host link LED
    output logic       status_ps4,      // Controller link LED
    output logic       status_debug     // Debug LED
);

    logic [`SUBSYS_SERVO_N-1:0] servo_en;
    reg_data_t                  servo_pos [`SUBSYS_SERVO_N];

    reg_bus_if u_bus ();

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////
    spi_target u_spi (
        .clock      (clock),
        .reset_n    (reset_n),
        .spi_clock  (spi_clock),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .miso       (miso),
        .bus        (u_bus.host)
    );

    reg_file u_regs (
        .clock          (clock),
        .reset_n        (reset_n),
        .bus            (u_bus.target),
        .sr_fault       (sr_fault),
        .servo_en       (servo_en),
        .servo_pos      (servo_pos),
        .status_fault   (status_fault),
        .status_pi      (status_pi),
        .status_ps4     (status_ps4),
        .status_debug   (status_debug)
    );

    servo_pwm u_servo_pwm (
        .clock      (clock),
        .reset_n    (reset_n),
        .servo_en   (servo_en),
        .servo_pos  (servo_pos),
        .servo_out  (servo_pwm)         // Channel i to arm servo i
    );

endmodule

// File: tb/subsys_properties.sv
// Concurrent checks on the subsystem top-level ports,
// bound into subsys_top

`timescale 1ns/1ps

module subsys_properties (
    input logic       clock,
    input logic       reset_n,
    input logic       cs_n,
    input logic       miso,
    input logic [3:0] servo_pwm,
    input logic       status_pi,
    input logic       status_debug
);

    // SPI output stays quiet while deselected
    miso_idle_low: assert property (@(posedge clock) cs_n |-> !miso)
        else $error("miso driven while cs_n is high");

    // PWM outputs held low through reset
    pwm_low_in_reset: assert property (@(posedge clock) !reset_n |-> servo_pwm == 4'h0)
        else $error("servo_pwm active during reset");

    // Debug LED only drops in test mode, which forces the pi LED on
    debug_implies_pi: assert property (@(posedge clock) disable iff (!reset_n)
        (status_debug !== 1'b1) |-> status_pi)
        else $error("status_debug low without status_pi high");

endmodule

bind subsys_top subsys_properties u_props (
    .clock        (clock),
    .reset_n      (reset_n),
    .cs_n         (cs_n),
    .miso         (miso),
    .servo_pwm    (servo_pwm),
    .status_pi    (status_pi),
    .status_debug (status_debug)
);

// File: tb/subsys_tb.sv
// Testbench for the control subsystem: clock, reset, SPI driver,
// register model, random register, fault, LED and servo PWM tests

`timescale 1ns/1ps
`include "subsys_macros.svh"

module subsys_tb
    import subsys_pkg::*;
();

    localparam int HALF_BIT  = 6;       // Clocks per SPI half period
    localparam int N_TRANS   = 100;     // Bound on SPI transactions
    localparam int N_PERIODS = 4;       // PWM periods waited and measured
    localparam int MARGIN    = 4000;    // Spare clocks for idle gaps

    logic       clock;
    logic       reset_n;
    logic       spi_clock;
    logic       cs_n;
    logic       mosi;
    logic       miso;
    logic [3:0] sr_fault;
    logic [3:0] servo_pwm;
    logic       status_fault, status_pi, status_ps4, status_debug;

    int         seed = 69103;           // Fixed random seed
    int         checks = 0;
    int         errors = 0;
    int         test_errors = 0;        // Error count at start of test
    reg_data_t  reg_model [64];         // Mirror of the register map

    subsys_top u_dut (
        .clock(clock), .reset_n(reset_n), .spi_clock(spi_clock), .cs_n(cs_n),
        .mosi(mosi), .miso(miso), .sr_fault(sr_fault), .servo_pwm(servo_pwm),
        .status_fault(status_fault), .status_pi(status_pi),
        .status_ps4(status_ps4), .status_debug(status_debug)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;      // 100 MHz
    end

    ////////////////////////////////////////////////////////////
    // Checks and SPI driver
    ////////////////////////////////////////////////////////////
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Mode 0 frame, MSB first, cut short when n_bits is below 16
    task automatic shift_frame(input logic [15:0] frame, input int n_bits,
                               output logic [7:0] rx);
        rx = '0;
        for (int i = 0; i < n_bits; i++) begin
            @(posedge clock);
            cs_n      <= 1'b0;
            spi_clock <= 1'b0;
            mosi      <= frame[15-i];
            repeat (HALF_BIT - 1) @(posedge clock);
            @(negedge clock);
            if (i >= 8)
                rx[15-i] = miso;        // Settled since the falling edge
            @(posedge clock);
            spi_clock <= 1'b1;
            repeat (HALF_BIT - 1) @(posedge clock);
        end
        @(posedge clock);
        spi_clock <= 1'b0;
        cs_n      <= 1'b1;
        mosi      <= 1'b0;
        repeat (8) @(posedge clock);    // Idle gap between frames
    endtask

    task automatic spi_write(input logic [5:0] addr, input logic [7:0] data);
        logic [7:0] rx_dummy;
        shift_frame({2'b10, addr, data}, 16, rx_dummy);
    endtask

    task automatic spi_read(input logic [5:0] addr, output logic [7:0] data);
        shift_frame({2'b00, addr, 8'h00}, 16, data);
    endtask

    // Expected LEDs as {fault, pi, ps4, debug}
    task automatic check_leds(input logic [7:0] led);
        logic [3:0] exp_leds;
        if (led[0])
            exp_leds = {led[1], 1'b1, 1'b1, led[4]};       // Test mode
        else
            exp_leds = {|sr_fault, led[2], led[3], 1'b1};
        check_value({status_fault, status_pi, status_ps4, status_debug}, exp_leds,
                    $sformatf("status LEDs for REG_LED %0h", led));
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    initial begin
        logic [7:0] rd;
        logic [5:0] addr;
        logic [7:0] data;
        logic [3:0] mask;
        logic [7:0] pos [4];
        int         high_cnt [4];
        reset_n   = 1'b0;
        spi_clock = 1'b0;
        cs_n      = 1'b1;
        mosi      = 1'b0;
        sr_fault  = 4'h0;
        foreach (reg_model[i])
            reg_model[i] = '0;
        reg_model[REG_ID] = `SUBSYS_ID;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;

        spi_read(REG_ID, rd);
        check_value(rd, `SUBSYS_ID, "ID register");
        addr = 6'(($unsigned($random(seed)) % 55) + 9);    // 0x09 to 0x3F
        spi_read(addr, rd);
        check_value(rd, 0, $sformatf("unmapped address %0h", addr));
        report_test("1 ID and unmapped reads");

        repeat (24) begin
            addr = 6'(($unsigned($random(seed)) % 7) + 1);  // Writable 0x01 to 0x07
            data = 8'($random(seed));
            spi_write(addr, data);
            reg_model[addr] = data;
            spi_read(addr, rd);
            check_value(rd, reg_model[addr], $sformatf("read back of register %0h", addr));
        end
        report_test("2 random write and read back");

        repeat (4) begin
            addr = 6'(($unsigned($random(seed)) % 7) + 1);
            data = ~reg_model[addr];                        // Would change the register
            shift_frame({2'b10, addr, data}, 12, rd);
            spi_read(addr, rd);
            check_value(rd, reg_model[addr], $sformatf("aborted write to %0h", addr));
        end
        report_test("3 aborted writes");

        spi_write(REG_LED, 8'h00);                          // Test mode off
        reg_model[REG_LED] = 8'h00;
        repeat (6) begin
            @(posedge clock);
            sr_fault <= 4'($random(seed));
            repeat (4) @(posedge clock);
            @(negedge clock);
            check_value(status_fault, |sr_fault, "status_fault as OR of faults");
            spi_read(REG_FAULT, rd);
            check_value(rd, {4'h0, sr_fault}, "REG_FAULT sample");
        end
        report_test("4 fault sampling");

        for (int k = 0; k < 8; k++) begin
            data    = 8'($random(seed)) & 8'h1F;
            data[0] = k[0];                                 // Both modes in turn
            spi_write(REG_LED, data);
            reg_model[REG_LED] = data;
            @(negedge clock);
            check_leds(data);
        end
        report_test("5 status LED multiplexer");

        for (int r = 0; r < 2; r++) begin
            mask       = 4'($random(seed));
            mask[r]    = 1'b1;                              // One channel on
            mask[r+2]  = 1'b0;                              // One channel off
            for (int ch = 0; ch < 4; ch++) begin
                pos[ch] = 8'($random(seed));
                spi_write(6'(REG_SERVO_POS0 + ch), pos[ch]);
                reg_model[REG_SERVO_POS0 + ch] = pos[ch];
            end
            spi_write(REG_SERVO_EN, {4'h0, mask});
            reg_model[REG_SERVO_EN] = {4'h0, mask};
            repeat (1024 + 8) @(posedge clock);             // Let a period start
            high_cnt = '{default: 0};
            repeat (1024) begin
                @(negedge clock);
                for (int ch = 0; ch < 4; ch++)
                    if (servo_pwm[ch])
                        high_cnt[ch]++;
            end
            for (int ch = 0; ch < 4; ch++)
                check_value(high_cnt[ch], mask[ch] ? int'(pos[ch]) * `SUBSYS_PWM_DIV : 0,
                            $sformatf("servo %0d high time", ch));
        end
        report_test("6 servo PWM high time");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog sized from frame length and PWM periods
    initial begin
        #((N_TRANS * 16 * 2 * HALF_BIT + N_PERIODS * 1024 + MARGIN) * 10);
        $display("Timeout: the tests did not finish within the watchdog limit");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/subsys_pkg.sv
hw/reg_bus_if.sv
hw/spi_target.sv
hw/reg_file.sv
hw/servo_pwm.sv
hw/subsys_top.sv
tb/subsys_properties.sv
tb/subsys_tb.sv

// File: Makefile
# Verilator simulation of the control subsystem testbench
TOP = subsys_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
